// File: spi_ioexp.f
+incdir+.
spi_pkg.sv
ioexp_pkg.sv
cdc_sync.sv
spi_slave.sv
spi_cmd_ctrl.sv
gpio_port.sv
reg_bank.sv
spi_ioexp_top.sv
tb_spi_ioexp.sv

// File: run_sim.sh
#!/bin/sh
# build and run the SPI I/O expander testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_spi_ioexp \
    -f spi_ioexp.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation clean"

// File: tb_spi_ioexp.sv
`timescale 1ns/1ps
`include "spi_ioexp_defines.svh"

module tb_spi_ioexp;

    // sclk half period in sysClk cycles
    localparam int HALF         = 10;
    localparam int MAX_DATA     = 6;
    localparam int NUM_RAND     = 200;
    localparam int CHURN_ROUNDS = 10;
    localparam int CHURN_FRAMES = 4;
    // longest frame, bits times two half periods, plus cs and idle gaps
    localparam int FRAME_CYC    = (2 + MAX_DATA) * 8 * 2 * HALF + 64;
    localparam int NUM_FRAMES   = 1 + NUM_RAND + 2 + CHURN_ROUNDS * (CHURN_FRAMES + 1);
    localparam int LIMIT_CYC    = NUM_FRAMES * FRAME_CYC + 2000;

    logic       sysClk;
    logic       rst_n_i;
    logic       spi_sclk_i;
    logic       spi_cs_n_i;
    logic       spi_mosi_i;
    logic       spi_miso_o;
    logic [7:0] pins_i;
    logic [7:0] pins_o;
    logic [7:0] pins_oe_o;

    // frame buffers, opcode and address first
    logic [7:0] mosi_buf [0:MAX_DATA+1];
    logic [7:0] miso_buf [0:MAX_DATA+1];

    // reference register file and pin level
    logic [7:0] model_regs [0:3];
    logic [7:0] pins_now;

    int errors;
    int checks;
    int cycles;

    spi_ioexp_top u_dut (
        .sysClk     (sysClk),
        .rst_n_i    (rst_n_i),
        .spi_sclk_i (spi_sclk_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_miso_o (spi_miso_o),
        .pins_i     (pins_i),
        .pins_o     (pins_o),
        .pins_oe_o  (pins_oe_o)
    );

    initial begin
        sysClk = 1'b0;
        forever #4 sysClk = ~sysClk;
    end

    // run limit
    always @(posedge sysClk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT_CYC) begin
            $display("run stopped after %0d cycles without finishing", LIMIT_CYC);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    // --------------------
    // SPI master, mode 0
    // --------------------
    task automatic spi_frame(input int nbytes, input bit churn, input int gap);
        @(posedge sysClk);
        spi_cs_n_i <= 1'b0;
        for (int i = 0; i < nbytes; i++) begin
            for (int b = 7; b >= 0; b--) begin
                // mosi moves with the falling edge
                spi_mosi_i <= mosi_buf[i][b];
                repeat (HALF - 1) @(posedge sysClk);
                // miso settled well before the rising edge
                @(negedge sysClk);
                miso_buf[i][b] = spi_miso_o;
                @(posedge sysClk);
                spi_sclk_i <= 1'b1;
                for (int c = 0; c < HALF; c++) begin
                    // pin change timed so the port write meets this byte's write
                    if (churn && b == 0 && c == 1) begin
                        pins_now = 8'($urandom);
                        pins_i  <= pins_now;
                    end
                    @(posedge sysClk);
                end
                spi_sclk_i <= 1'b0;
            end
        end
        repeat (HALF) @(posedge sysClk);
        spi_cs_n_i <= 1'b1;
        spi_mosi_i <= 1'b0;
        repeat (gap) @(posedge sysClk);
    endtask

    // what a read of one register should return
    function automatic logic [7:0] expect_reg(input logic [1:0] a);
        // gpio reads the pins through the polarity mask
        if (a == `IOEXP_REG_GPIO) begin
            return pins_now ^ model_regs[`IOEXP_REG_IPOL];
        end
        return model_regs[a];
    endfunction

    task automatic write_frame(input logic [1:0] start, input int len, input bit churn,
                               input int gap);
        logic [1:0] a;
        mosi_buf[0] = {`IOEXP_DEV_ADDR, 1'b0};
        mosi_buf[1] = {6'd0, start};
        a = start;
        for (int i = 0; i < len; i++) begin
            mosi_buf[i+2] = 8'($urandom);
            // host writes to gpio land in the latch
            if (a == `IOEXP_REG_GPIO) begin
                model_regs[`IOEXP_REG_OLAT] = mosi_buf[i+2];
            end else begin
                model_regs[a] = mosi_buf[i+2];
            end
            a = a + 2'd1;
        end
        spi_frame(len + 2, churn, gap);
    endtask

    task automatic read_frame(input logic [1:0] start, input int len);
        logic [1:0] a;
        logic [7:0] exp_val;
        mosi_buf[0] = {`IOEXP_DEV_ADDR, 1'b1};
        mosi_buf[1] = {6'd0, start};
        // data bytes from the master are don't care
        for (int i = 0; i < len; i++) begin
            mosi_buf[i+2] = 8'($urandom);
        end
        spi_frame(len + 2, 1'b0, 2);
        a = start;
        for (int i = 0; i < len; i++) begin
            exp_val = expect_reg(a);
            checks++;
            if (miso_buf[i+2] !== exp_val) begin
                errors++;
                $display("ERR %0t: read reg %0d got %02h expected %02h",
                         $time, a, miso_buf[i+2], exp_val);
            end
            a = a + 2'd1;
        end
    endtask

    // frame for another device on the bus
    task automatic foreign_frame(input int len);
        logic [6:0] dev;
        dev = 7'($urandom);
        if (dev == `IOEXP_DEV_ADDR) begin
            dev = dev + 7'd1;
        end
        mosi_buf[0] = {dev, 1'($urandom)};
        for (int i = 1; i < len + 2; i++) begin
            mosi_buf[i] = 8'($urandom);
        end
        spi_frame(len + 2, 1'b0, 2);
        for (int i = 0; i < len + 2; i++) begin
            checks++;
            if (miso_buf[i] !== 8'h00) begin
                errors++;
                $display("ERR %0t: foreign frame byte %0d got %02h expected 00",
                         $time, i, miso_buf[i]);
            end
        end
    endtask

    task automatic check_pins();
        @(negedge sysClk);
        checks++;
        if (pins_o !== model_regs[`IOEXP_REG_OLAT]) begin
            errors++;
            $display("ERR %0t: pins_o got %02h expected %02h",
                     $time, pins_o, model_regs[`IOEXP_REG_OLAT]);
        end
        checks++;
        if (pins_oe_o !== ~model_regs[`IOEXP_REG_IODIR]) begin
            errors++;
            $display("ERR %0t: pins_oe_o got %02h expected %02h",
                     $time, pins_oe_o, ~model_regs[`IOEXP_REG_IODIR]);
        end
    endtask

    // pin change between frames, then settle
    task automatic set_pins(input logic [7:0] v);
        @(posedge sysClk);
        pins_now = v;
        pins_i  <= v;
        repeat (20) @(posedge sysClk);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int kind;
        int len;
        logic [1:0] start;
        rst_n_i    <= 1'b0;
        spi_sclk_i <= 1'b0;
        spi_cs_n_i <= 1'b1;
        spi_mosi_i <= 1'b0;
        pins_i     <= 8'h00;
        pins_now = 8'h00;
        model_regs[`IOEXP_REG_IODIR] = `IOEXP_IODIR_RST;
        model_regs[`IOEXP_REG_IPOL]  = 8'h00;
        model_regs[`IOEXP_REG_GPIO]  = 8'h00;
        model_regs[`IOEXP_REG_OLAT]  = 8'h00;
        void'($urandom(32'h8f2a_4a52));
        repeat (16) @(posedge sysClk);
        rst_n_i <= 1'b1;
        repeat (4) @(posedge sysClk);

        // reset state
        @(negedge sysClk);
        checks++;
        if (spi_miso_o !== 1'b0) begin
            errors++;
            $display("ERR %0t: miso got %b after reset expected 0", $time, spi_miso_o);
        end
        read_frame(2'd0, 4);
        check_pins();

        // random mix of writes, reads, foreign frames and pin reads
        for (int n = 0; n < NUM_RAND; n++) begin
            kind  = $urandom_range(0, 7);
            len   = $urandom_range(1, MAX_DATA);
            start = 2'($urandom);
            if (kind == 7) begin
                set_pins(8'($urandom));
            end else begin
                repeat (20) @(posedge sysClk);
            end
            if (kind <= 3) begin
                write_frame(start, len, 1'b0, 2);
            end else if (kind <= 5) begin
                read_frame(start, len);
            end else if (kind == 6) begin
                foreign_frame(len);
            end else begin
                read_frame(`IOEXP_REG_GPIO, 1);
            end
            check_pins();
        end

        // host write to gpio address, read back through OLAT
        repeat (20) @(posedge sysClk);
        write_frame(`IOEXP_REG_GPIO, 1, 1'b0, 2);
        check_pins();
        repeat (20) @(posedge sysClk);
        read_frame(`IOEXP_REG_OLAT, 1);

        // back-to-back writes with the pins moving underneath
        for (int r = 0; r < CHURN_ROUNDS; r++) begin
            for (int f = 0; f < CHURN_FRAMES; f++) begin
                write_frame(2'($urandom), $urandom_range(1, MAX_DATA), 1'b1, 4);
            end
            repeat (20) @(posedge sysClk);
            read_frame(2'd0, 4);
            check_pins();
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: spi_ioexp_top.sv
`timescale 1ns/1ps

module spi_ioexp_top import ioexp_pkg::*; (
    input  logic      sysClk,
    input  logic      rst_n_i,
    input  logic      spi_sclk_i,
    input  logic      spi_cs_n_i,
    input  logic      spi_mosi_i,
    output logic      spi_miso_o,
    input  reg_data_t pins_i,
    output reg_data_t pins_o,
    output reg_data_t pins_oe_o
);

    // byte stream
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       frame_start;
    logic [7:0] tx_byte;
    logic       tx_valid;

    // --------------------
    // register bus
    // --------------------
    logic       spi_req_valid;
    reg_req_t   spi_req;
    logic       spi_req_ready;
    logic       spi_rsp_valid;
    reg_rsp_t   spi_rsp;
    logic       gp_req_valid;
    reg_req_t   gp_req;
    logic       gp_req_ready;
    cfg_state_t cfg;

    spi_slave u_spi_slave (
        .sysClk        (sysClk),
        .rst_n_i       (rst_n_i),
        .spi_sclk_i    (spi_sclk_i),
        .spi_cs_n_i    (spi_cs_n_i),
        .spi_mosi_i    (spi_mosi_i),
        .spi_miso_o    (spi_miso_o),
        .tx_byte_i     (tx_byte),
        .tx_valid_i    (tx_valid),
        .rx_byte_o     (rx_byte),
        .rx_valid_o    (rx_valid),
        .frame_start_o (frame_start)
    );

    spi_cmd_ctrl u_spi_cmd_ctrl (
        .sysClk        (sysClk),
        .rst_n_i       (rst_n_i),
        .rx_byte_i     (rx_byte),
        .rx_valid_i    (rx_valid),
        .frame_start_i (frame_start),
        .tx_byte_o     (tx_byte),
        .tx_valid_o    (tx_valid),
        .req_valid_o   (spi_req_valid),
        .req_o         (spi_req),
        .req_ready_i   (spi_req_ready),
        .rsp_valid_i   (spi_rsp_valid),
        .rsp_i         (spi_rsp)
    );

    gpio_port u_gpio_port (
        .sysClk      (sysClk),
        .rst_n_i     (rst_n_i),
        .pins_i      (pins_i),
        .cfg_i       (cfg),
        .pins_o      (pins_o),
        .pins_oe_o   (pins_oe_o),
        .req_valid_o (gp_req_valid),
        .req_o       (gp_req),
        .req_ready_i (gp_req_ready)
    );

    reg_bank u_reg_bank (
        .sysClk          (sysClk),
        .rst_n_i         (rst_n_i),
        .spi_req_valid_i (spi_req_valid),
        .spi_req_i       (spi_req),
        .spi_req_ready_o (spi_req_ready),
        .spi_rsp_valid_o (spi_rsp_valid),
        .spi_rsp_o       (spi_rsp),
        .gp_req_valid_i  (gp_req_valid),
        .gp_req_i        (gp_req),
        .gp_req_ready_o  (gp_req_ready),
        .cfg_o           (cfg)
    );

endmodule

// File: reg_bank.sv
`timescale 1ns/1ps
`include "spi_ioexp_defines.svh"

module reg_bank import ioexp_pkg::*; (
    input  logic       sysClk,
    input  logic       rst_n_i,
    input  logic       spi_req_valid_i,
    input  reg_req_t   spi_req_i,
    output logic       spi_req_ready_o,
    output logic       spi_rsp_valid_o,
    output reg_rsp_t   spi_rsp_o,
    input  logic       gp_req_valid_i,
    input  reg_req_t   gp_req_i,
    output logic       gp_req_ready_o,
    output cfg_state_t cfg_o
);

    reg_data_t regs [`IOEXP_NUM_REGS];
    logic      spi_fire;
    logic      gp_fire;

    // --------------------
    // fixed priority, SPI first
    // --------------------
    assign spi_req_ready_o = spi_req_valid_i;
    assign gp_req_ready_o  = gp_req_valid_i & ~spi_req_valid_i;
    assign spi_fire        = spi_req_valid_i & spi_req_ready_o;
    assign gp_fire         = gp_req_valid_i & gp_req_ready_o;

    always_ff @(posedge sysClk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `IOEXP_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            regs[`IOEXP_REG_IODIR] <= `IOEXP_IODIR_RST;
            spi_rsp_valid_o        <= 1'b0;
        end else begin
            spi_rsp_valid_o <= spi_fire & ~spi_req_i.we;
            if (spi_fire && spi_req_i.we) begin
                // GPIO writes from the host go to the latch
                if (spi_req_i.addr == `IOEXP_REG_GPIO) begin
                    regs[`IOEXP_REG_OLAT] <= spi_req_i.wdata;
                end else begin
                    regs[spi_req_i.addr] <= spi_req_i.wdata;
                end
            end
            // port side only ever updates GPIO
            if (gp_fire && gp_req_i.we && gp_req_i.addr == `IOEXP_REG_GPIO) begin
                regs[`IOEXP_REG_GPIO] <= gp_req_i.wdata;
            end
        end
    end

    // read data, one cycle after the handshake
    always_ff @(posedge sysClk) begin
        if (spi_fire) begin
            spi_rsp_o.rdata <= regs[spi_req_i.addr];
        end
    end

    assign cfg_o.iodir = regs[`IOEXP_REG_IODIR];
    assign cfg_o.ipol  = regs[`IOEXP_REG_IPOL];
    assign cfg_o.olat  = regs[`IOEXP_REG_OLAT];

endmodule

// File: gpio_port.sv
`timescale 1ns/1ps
`include "spi_ioexp_defines.svh"

module gpio_port import ioexp_pkg::*; (
    input  logic       sysClk,
    input  logic       rst_n_i,
    input  reg_data_t  pins_i,
    input  cfg_state_t cfg_i,
    output reg_data_t  pins_o,
    output reg_data_t  pins_oe_o,
    output logic       req_valid_o,
    output reg_req_t   req_o,
    input  logic       req_ready_i
);

    reg_data_t pin_meta_q;
    reg_data_t pin_sync_q;
    // value last accepted by the bank
    reg_data_t last_q;
    // what the GPIO register ought to hold
    reg_data_t want;

    assign want = pin_sync_q ^ cfg_i.ipol;

    always_ff @(posedge sysClk) begin
        if (!rst_n_i) begin
            pin_meta_q  <= '0;
            pin_sync_q  <= '0;
            last_q      <= '0;
            req_valid_o <= 1'b0;
            pins_o      <= '0;
            pins_oe_o   <= '0;
        end else begin
            pin_meta_q <= pins_i;
            pin_sync_q <= pin_meta_q;
            if (req_valid_o) begin
                if (req_ready_i) begin
                    req_valid_o <= 1'b0;
                    last_q      <= req_o.wdata;
                end
            end else if (want != last_q) begin
                req_valid_o <= 1'b1;
            end
            // drive only where IODIR says output
            pins_o    <= cfg_i.olat;
            pins_oe_o <= ~cfg_i.iodir;
        end
    end

    // payload tracks the newest sample while idle
    always_ff @(posedge sysClk) begin
        if (!req_valid_o) begin
            req_o.we    <= 1'b1;
            req_o.addr  <= `IOEXP_REG_GPIO;
            req_o.wdata <= want;
        end
    end

endmodule

// File: spi_cmd_ctrl.sv
`timescale 1ns/1ps
`include "spi_ioexp_defines.svh"

module spi_cmd_ctrl import spi_pkg::*, ioexp_pkg::*; (
    input  logic      sysClk,
    input  logic      rst_n_i,
    input  spi_byte_t rx_byte_i,
    input  logic      rx_valid_i,
    input  logic      frame_start_i,
    output spi_byte_t tx_byte_o,
    output logic      tx_valid_o,
    output logic      req_valid_o,
    output reg_req_t  req_o,
    input  logic      req_ready_i,
    input  logic      rsp_valid_i,
    input  reg_rsp_t  rsp_i
);

    frame_phase_e phase_q;
    // r/w bit of the opcode, 1 = read
    logic         rd_q;
    reg_addr_t    addr_q;
    reg_addr_t    addr_nxt;
    reg_addr_t    rx_addr;

    // wraps inside the four registers
    assign addr_nxt = addr_q + 1'b1;
    assign rx_addr  = reg_addr_t'(rx_byte_i);

    // --------------------
    // frame decoder
    // --------------------
    always_ff @(posedge sysClk) begin
        if (!rst_n_i) begin
            phase_q     <= PH_OPCODE;
            rd_q        <= 1'b0;
            addr_q      <= '0;
            req_valid_o <= 1'b0;
            tx_valid_o  <= 1'b0;
        end else begin
            if (req_valid_o && req_ready_i) begin
                req_valid_o <= 1'b0;
            end
            // prefetched read data ready for the slave
            if (rsp_valid_i) begin
                tx_valid_o <= 1'b1;
            end
            if (frame_start_i) begin
                phase_q    <= PH_OPCODE;
                tx_valid_o <= 1'b0;
            end else if (rx_valid_i) begin
                case (phase_q)
                    PH_OPCODE: begin
                        if (rx_byte_i[7:1] == `IOEXP_DEV_ADDR) begin
                            phase_q <= PH_ADDR;
                            rd_q    <= rx_byte_i[0];
                        end else begin
                            phase_q <= PH_IGNORE;
                        end
                    end
                    PH_ADDR: begin
                        phase_q <= PH_DATA;
                        addr_q  <= rx_addr;
                        // fetch the first byte to send back
                        if (rd_q) begin
                            req_valid_o <= 1'b1;
                        end
                    end
                    PH_DATA: begin
                        addr_q      <= addr_nxt;
                        tx_valid_o  <= 1'b0;
                        // write this byte, or prefetch the next one
                        req_valid_o <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // request payload, follows the same decisions
    always_ff @(posedge sysClk) begin
        if (rx_valid_i && !frame_start_i) begin
            if (phase_q == PH_ADDR) begin
                req_o.we    <= 1'b0;
                req_o.addr  <= rx_addr;
                req_o.wdata <= '0;
            end else if (phase_q == PH_DATA) begin
                req_o.we    <= ~rd_q;
                req_o.addr  <= rd_q ? addr_nxt : addr_q;
                req_o.wdata <= rx_byte_i;
            end
        end
        if (rsp_valid_i) begin
            tx_byte_o <= rsp_i.rdata;
        end
    end

endmodule

// File: spi_slave.sv
`timescale 1ns/1ps

module spi_slave import spi_pkg::*; (
    input  logic      sysClk,
    input  logic      rst_n_i,
    input  logic      spi_sclk_i,
    input  logic      spi_cs_n_i,
    input  logic      spi_mosi_i,
    output logic      spi_miso_o,
    input  spi_byte_t tx_byte_i,
    input  logic      tx_valid_i,
    output spi_byte_t rx_byte_o,
    output logic      rx_valid_o,
    output logic      frame_start_o
);

    // --------------------
    // input synchronizers
    // --------------------
    logic sclk_rise;
    logic sclk_fall;
    logic mosi_sync;
    logic cs_sync;
    logic cs_fall;

    cdc_sync u_sync_sclk (
        .sysClk    (sysClk),
        .rst_n_i   (rst_n_i),
        .async_i   (spi_sclk_i),
        .sync_o    (),
        .rising_o  (sclk_rise),
        .falling_o (sclk_fall)
    );

    // same latency as sclk, so level is valid on the rise pulse
    cdc_sync u_sync_mosi (
        .sysClk    (sysClk),
        .rst_n_i   (rst_n_i),
        .async_i   (spi_mosi_i),
        .sync_o    (mosi_sync),
        .rising_o  (),
        .falling_o ()
    );

    // chip select idles high
    cdc_sync #(.RST_VAL(1'b1)) u_sync_cs (
        .sysClk    (sysClk),
        .rst_n_i   (rst_n_i),
        .async_i   (spi_cs_n_i),
        .sync_o    (cs_sync),
        .rising_o  (),
        .falling_o (cs_fall)
    );

    // --------------------
    // shifters
    // --------------------
    // counts rising edges within the byte
    logic [2:0] bit_cnt;
    spi_byte_t  rx_shift;
    // bit 7 is the bit currently on miso
    spi_byte_t  tx_shift;
    spi_byte_t  next_tx;
    logic       miso_q;

    // late data goes out as 00
    assign next_tx = tx_valid_i ? tx_byte_i : '0;

    always_ff @(posedge sysClk) begin
        if (!rst_n_i) begin
            bit_cnt       <= '0;
            miso_q        <= 1'b0;
            rx_valid_o    <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            rx_valid_o    <= 1'b0;
            frame_start_o <= cs_fall;
            if (cs_sync) begin
                // deselected, park everything
                bit_cnt <= '0;
                miso_q  <= 1'b0;
            end else if (cs_fall) begin
                // opcode byte answers with zeros
                bit_cnt <= '0;
                miso_q  <= 1'b0;
            end else begin
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        rx_valid_o <= 1'b1;
                    end
                end
                if (sclk_fall) begin
                    // byte boundary loads the next tx byte
                    miso_q <= (bit_cnt == 3'd0) ? next_tx[7] : tx_shift[6];
                end
            end
        end
    end

    always_ff @(posedge sysClk) begin
        if (cs_fall) begin
            tx_shift <= '0;
        end else if (sclk_fall) begin
            tx_shift <= (bit_cnt == 3'd0) ? next_tx : {tx_shift[6:0], 1'b0};
        end
        if (sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_sync};
            if (bit_cnt == 3'd7) begin
                rx_byte_o <= {rx_shift[6:0], mosi_sync};
            end
        end
    end

    assign spi_miso_o = miso_q;

endmodule

// File: cdc_sync.sv
`timescale 1ns/1ps

module cdc_sync #(
    // idle level of the input, avoids a false edge out of reset
    parameter logic RST_VAL = 1'b0
) (
    input  logic sysClk,
    input  logic rst_n_i,
    input  logic async_i,
    output logic sync_o,
    output logic rising_o,
    output logic falling_o
);

    // first stage may go metastable
    logic meta_q;
    logic sync_q;
    // last synced level, for edge compare
    logic hist_q;

    always_ff @(posedge sysClk) begin
        if (!rst_n_i) begin
            meta_q <= RST_VAL;
            sync_q <= RST_VAL;
            hist_q <= RST_VAL;
        end else begin
            meta_q <= async_i;
            sync_q <= meta_q;
            hist_q <= sync_q;
        end
    end

    assign sync_o    = sync_q;
    // one-cycle pulses
    assign rising_o  = sync_q & ~hist_q;
    assign falling_o = ~sync_q & hist_q;

endmodule

// File: ioexp_pkg.sv
`include "spi_ioexp_defines.svh"

package ioexp_pkg;

    // --------------------
    // register bus
    // --------------------
    typedef logic [$clog2(`IOEXP_NUM_REGS)-1:0] reg_addr_t;
    typedef logic [7:0]                         reg_data_t;

    // held stable with valid until ready
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    // valid one cycle after a read handshake
    typedef struct packed {
        reg_data_t rdata;
    } reg_rsp_t;

    // config seen by the pin logic
    typedef struct packed {
        reg_data_t iodir;
        reg_data_t ipol;
        reg_data_t olat;
    } cfg_state_t;

endpackage

// File: spi_pkg.sv
package spi_pkg;

    // one byte on the SPI wire, msb first
    typedef logic [7:0] spi_byte_t;

    // where the decoder sits inside a chip-select frame
    typedef enum logic [1:0] {
        PH_OPCODE,
        PH_ADDR,
        PH_DATA,
        // wrong device address, skip to end of frame
        PH_IGNORE
    } frame_phase_e;

endpackage

// File: spi_ioexp_defines.svh
`ifndef SPI_IOEXP_DEFINES_SVH
`define SPI_IOEXP_DEFINES_SVH

// opcode upper seven bits, MCP23S17 style with A2..A0 tied low
`define IOEXP_DEV_ADDR 7'h20

// one port only
`define IOEXP_NUM_REGS 4

// all pins come up as inputs
`define IOEXP_IODIR_RST 8'hFF

// --------------------
// register map
// --------------------
`define IOEXP_REG_IODIR 2'd0
`define IOEXP_REG_IPOL  2'd1
`define IOEXP_REG_GPIO  2'd2
`define IOEXP_REG_OLAT  2'd3

`endif
